// File: verilog/int_exec_pkg.sv
// Shared types of the integer execute stage: scalar, ALU ops, branch kinds, instruction, status
package int_exec_pkg;

    // Lane geometry
    localparam int SCALAR_WIDTH = 32;
    localparam int SHIFT_BITS = $clog2(SCALAR_WIDTH);
    // One extra bit so an all-zero input can report 32
    localparam int COUNT_WIDTH = $clog2(SCALAR_WIDTH) + 1;

    typedef logic [SCALAR_WIDTH-1:0] scalar_t;

    // Lane operations; gaps are ops handled by other pipelines
    typedef enum logic [5:0] {
        OP_OR       = 6'b000000,
        OP_AND      = 6'b000001,
        OP_XOR      = 6'b000011,
        OP_ADD_I    = 6'b000101,
        OP_SUB_I    = 6'b000110,
        OP_ASHR     = 6'b001001,
        OP_SHR      = 6'b001010,
        OP_SHL      = 6'b001011,
        OP_CLZ      = 6'b001100,
        OP_CTZ      = 6'b001110,
        OP_MOVE     = 6'b001111,
        OP_CMPEQ_I  = 6'b010000,
        OP_CMPNE_I  = 6'b010001,
        OP_CMPGT_I  = 6'b010010,
        OP_CMPGE_I  = 6'b010011,
        OP_CMPLT_I  = 6'b010100,
        OP_CMPLE_I  = 6'b010101,
        OP_CMPGT_U  = 6'b010110,
        OP_CMPGE_U  = 6'b010111,
        OP_CMPLT_U  = 6'b011000,
        OP_CMPLE_U  = 6'b011001,
        OP_SEXT8    = 6'b011101,
        OP_SEXT16   = 6'b011110
    } alu_op_t;

    typedef enum logic [2:0] {
        BRANCH_REGISTER      = 3'b000,
        BRANCH_ZERO          = 3'b001,
        BRANCH_NOT_ZERO      = 3'b010,
        BRANCH_ALWAYS        = 3'b011,
        BRANCH_CALL_OFFSET   = 3'b100,
        BRANCH_ERET          = 3'b101,
        BRANCH_CALL_REGISTER = 3'b110
    } branch_type_t;

    // Only PIPE_INT_ARITH instructions are executed by this stage
    typedef enum logic [1:0] {
        PIPE_MEM         = 2'd0,
        PIPE_INT_ARITH   = 2'd1,
        PIPE_FLOAT_ARITH = 2'd2
    } pipe_sel_t;

    typedef struct packed {
        alu_op_t      alu_op;
        logic         branch;
        branch_type_t branch_type;
        pipe_sel_t    pipeline_sel;
        scalar_t      pc;
        scalar_t      immediate_value;
    } instruction_t;

    typedef struct packed {
        logic    instruction_valid;
        logic    rollback_en;
        scalar_t rollback_pc;
        logic    privileged_op_fault;
    } ix_status_t;

    typedef struct packed {
        logic uncond_branch;
        logic cond_branch_taken;
        logic cond_branch_not_taken;
    } perf_events_t;

endpackage

// File: verilog/zero_counter.sv
// zero_counter: leading and trailing zero counts of one scalar
`timescale 1ns/1ps

module zero_counter(
    input int_exec_pkg::scalar_t                  value,
    output logic [int_exec_pkg::COUNT_WIDTH-1:0]  leading,
    output logic [int_exec_pkg::COUNT_WIDTH-1:0]  trailing);

    import int_exec_pkg::*;

    // Leading zeros
    // Scan upward so the highest set bit is the last one to write
    always_comb
    begin
        leading = COUNT_WIDTH'(SCALAR_WIDTH);
        for (int i = 0; i < SCALAR_WIDTH; i++)
        begin
            if (value[i])
            begin
                leading = COUNT_WIDTH'(SCALAR_WIDTH - 1 - i);
            end
        end
    end

    // Trailing zeros
    // Scan downward, lowest set bit wins
    always_comb
    begin
        trailing = COUNT_WIDTH'(SCALAR_WIDTH);
        for (int i = SCALAR_WIDTH - 1; i >= 0; i--)
        begin
            if (value[i])
            begin
                trailing = COUNT_WIDTH'(i);
            end
        end
    end

    // A zero input leaves both counts at the full width.
    // That is the value software expects from clz/ctz of 0

endmodule

// File: verilog/lane_alu.sv
// lane_alu: single-lane integer ALU with compares, shifts, zero counts and sign extension
`timescale 1ns/1ps

module lane_alu(
    input int_exec_pkg::alu_op_t    alu_op,
    input int_exec_pkg::scalar_t    operand1,
    input int_exec_pkg::scalar_t    operand2,
    output int_exec_pkg::scalar_t   result);

    import int_exec_pkg::*;

    scalar_t difference;
    scalar_t sum;
    scalar_t right_shift;
    logic borrow;
    logic negative;
    logic overflow;
    logic zero;
    logic signed_gtr;
    logic shift_in_sign;
    logic [SHIFT_BITS-1:0] shift_amount;
    logic [COUNT_WIDTH-1:0] lz;
    logic [COUNT_WIDTH-1:0] tz;

    // One subtractor feeds SUB and every compare
    assign {borrow, difference} = {1'b0, operand1} - {1'b0, operand2};
    assign negative = difference[SCALAR_WIDTH-1];
    assign overflow = operand2[SCALAR_WIDTH-1] == negative
        && operand1[SCALAR_WIDTH-1] != operand2[SCALAR_WIDTH-1];
    assign zero = difference == '0;
    assign signed_gtr = overflow == negative;

    assign sum = operand1 + operand2;

    // Shift amount is taken modulo the lane width
    assign shift_amount = operand2[SHIFT_BITS-1:0];
    assign shift_in_sign = alu_op == OP_ASHR ? operand1[SCALAR_WIDTH-1] : 1'b0;
    assign right_shift = scalar_t'({{SCALAR_WIDTH{shift_in_sign}}, operand1} >> shift_amount);

    zero_counter u_zero_counter(
        .value(operand2),
        .leading(lz),
        .trailing(tz));

    always_comb
    begin
        case (alu_op)
            OP_OR:      result = operand1 | operand2;
            OP_AND:     result = operand1 & operand2;
            OP_XOR:     result = operand1 ^ operand2;
            OP_ADD_I:   result = sum;
            OP_SUB_I:   result = difference;
            OP_MOVE:    result = operand2;
            OP_SHL:     result = operand1 << shift_amount;
            OP_SHR,
            OP_ASHR:    result = right_shift;
            OP_CLZ:     result = scalar_t'(lz);
            OP_CTZ:     result = scalar_t'(tz);
            // Compares give 0 or 1
            OP_CMPEQ_I: result = scalar_t'(zero);
            OP_CMPNE_I: result = scalar_t'(!zero);
            OP_CMPGT_I: result = scalar_t'(signed_gtr && !zero);
            OP_CMPGE_I: result = scalar_t'(signed_gtr || zero);
            OP_CMPLT_I: result = scalar_t'(!signed_gtr && !zero);
            OP_CMPLE_I: result = scalar_t'(!signed_gtr || zero);
            OP_CMPGT_U: result = scalar_t'(!borrow && !zero);
            OP_CMPGE_U: result = scalar_t'(!borrow || zero);
            OP_CMPLT_U: result = scalar_t'(borrow && !zero);
            OP_CMPLE_U: result = scalar_t'(borrow || zero);
            OP_SEXT8:   result = scalar_t'($signed(operand2[7:0]));
            OP_SEXT16:  result = scalar_t'($signed(operand2[15:0]));
            default:    result = '0;
        endcase
    end

endmodule

// File: verilog/vector_alu.sv
// vector_alu: lane ALU array with registered result vector and passthrough fields
`timescale 1ns/1ps

module vector_alu #(
    parameter int NUM_LANES = 4,
    parameter int NUM_THREADS = 4,
    localparam int THREAD_IDX_WIDTH = $clog2(NUM_THREADS),
    localparam int SUBCYCLE_WIDTH = $clog2(NUM_LANES)
)(
    input                                   clk,
    input int_exec_pkg::scalar_t            operand1[NUM_LANES],
    input int_exec_pkg::scalar_t            operand2[NUM_LANES],
    input logic [NUM_LANES-1:0]             mask_value,
    input int_exec_pkg::instruction_t       instruction,
    input logic [THREAD_IDX_WIDTH-1:0]      thread_idx,
    input logic [SUBCYCLE_WIDTH-1:0]        subcycle,
    output int_exec_pkg::scalar_t           result[NUM_LANES],
    output logic [NUM_LANES-1:0]            mask_value_q,
    output int_exec_pkg::instruction_t      instruction_q,
    output logic [THREAD_IDX_WIDTH-1:0]     thread_idx_q,
    output logic [SUBCYCLE_WIDTH-1:0]       subcycle_q);

    import int_exec_pkg::*;

    scalar_t lane_result[NUM_LANES];

    // All lanes run the same op from the instruction
    genvar lane;
    generate
        for (lane = 0; lane < NUM_LANES; lane++)
        begin : lane_gen
            lane_alu u_lane_alu(
                .alu_op(instruction.alu_op),
                .operand1(operand1[lane]),
                .operand2(operand2[lane]),
                .result(lane_result[lane]));
        end
    endgenerate

    // Data path only, validity travels through the branch unit
    always_ff @(posedge clk)
    begin
        result <= lane_result;
        mask_value_q <= mask_value;
        instruction_q <= instruction;
        thread_idx_q <= thread_idx;
        subcycle_q <= subcycle;
    end

endmodule

// File: verilog/branch_unit.sv
// branch_unit: instruction qualification, branch decision, rollback target, fault and perf events
`timescale 1ns/1ps

module branch_unit #(
    parameter int NUM_THREADS = 4,
    localparam int THREAD_IDX_WIDTH = $clog2(NUM_THREADS)
)(
    input                                   clk,
    input                                   reset,
    input                                   instruction_valid,
    input int_exec_pkg::instruction_t       instruction,
    input logic [THREAD_IDX_WIDTH-1:0]      thread_idx,
    input int_exec_pkg::scalar_t            operand1_lane0,
    input                                   rollback_en,
    input logic [THREAD_IDX_WIDTH-1:0]      rollback_thread_idx,
    input int_exec_pkg::scalar_t            eret_address[NUM_THREADS],
    input logic                             supervisor_en[NUM_THREADS],
    output int_exec_pkg::ix_status_t        status,
    output int_exec_pkg::perf_events_t      perf);

    import int_exec_pkg::*;

    logic valid_instruction;
    logic eret;
    logic privileged_op_fault;
    logic branch_taken;
    logic conditional_branch;
    scalar_t target_pc;
    ix_status_t status_next;
    perf_events_t perf_next;

    // Squashed by a rollback of the same thread, or meant for another pipe
    assign valid_instruction = instruction_valid
        && (!rollback_en || rollback_thread_idx != thread_idx)
        && instruction.pipeline_sel == PIPE_INT_ARITH;

    assign eret = valid_instruction
        && instruction.branch
        && instruction.branch_type == BRANCH_ERET;
    assign privileged_op_fault = eret && !supervisor_en[thread_idx];

    // Taken decision
    always_comb
    begin
        branch_taken = 1'b0;
        conditional_branch = 1'b0;
        if (valid_instruction && instruction.branch && !privileged_op_fault)
        begin
            case (instruction.branch_type)
                BRANCH_ZERO:
                begin
                    conditional_branch = 1'b1;
                    branch_taken = operand1_lane0 == '0;
                end
                BRANCH_NOT_ZERO:
                begin
                    conditional_branch = 1'b1;
                    branch_taken = operand1_lane0 != '0;
                end
                BRANCH_ALWAYS,
                BRANCH_CALL_OFFSET,
                BRANCH_CALL_REGISTER,
                BRANCH_REGISTER,
                BRANCH_ERET:
                    branch_taken = 1'b1;
                default:
                    branch_taken = 1'b0;
            endcase
        end
    end

    // Rollback target
    always_comb
    begin
        case (instruction.branch_type)
            BRANCH_REGISTER,
            BRANCH_CALL_REGISTER: target_pc = operand1_lane0;
            BRANCH_ERET:          target_pc = eret_address[thread_idx];
            default:              target_pc = instruction.pc + instruction.immediate_value;
        endcase
    end

    always_comb
    begin
        status_next.instruction_valid = valid_instruction;
        status_next.rollback_en = branch_taken;
        status_next.rollback_pc = target_pc;
        status_next.privileged_op_fault = privileged_op_fault;
        perf_next.uncond_branch = !conditional_branch && branch_taken;
        perf_next.cond_branch_taken = conditional_branch && branch_taken;
        perf_next.cond_branch_not_taken = conditional_branch && !branch_taken;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            status <= '0;
            perf <= '0;
        end
        else
        begin
            status <= status_next;
            perf <= perf_next;
        end
    end

endmodule

// File: verilog/int_execute_stage.sv
// int_execute_stage: integer execute stage top, vector ALU plus branch unit
`timescale 1ns/1ps

module int_execute_stage #(
    parameter int NUM_LANES = 4,
    parameter int NUM_THREADS = 4,
    localparam int THREAD_IDX_WIDTH = $clog2(NUM_THREADS),
    localparam int SUBCYCLE_WIDTH = $clog2(NUM_LANES)
)(
    input                                   clk,
    input                                   reset,

    // Operand fetch
    input int_exec_pkg::scalar_t            of_operand1[NUM_LANES],
    input int_exec_pkg::scalar_t            of_operand2[NUM_LANES],
    input logic [NUM_LANES-1:0]             of_mask_value,
    input                                   of_instruction_valid,
    input int_exec_pkg::instruction_t       of_instruction,
    input logic [THREAD_IDX_WIDTH-1:0]      of_thread_idx,
    input logic [SUBCYCLE_WIDTH-1:0]        of_subcycle,

    // Writeback
    input                                   wb_rollback_en,
    input logic [THREAD_IDX_WIDTH-1:0]      wb_rollback_thread_idx,

    // Control registers, one entry per thread
    input int_exec_pkg::scalar_t            cr_eret_address[NUM_THREADS],
    input logic                             cr_supervisor_en[NUM_THREADS],

    // To writeback and perf counters
    output int_exec_pkg::scalar_t           ix_result[NUM_LANES],
    output logic [NUM_LANES-1:0]            ix_mask_value,
    output int_exec_pkg::instruction_t      ix_instruction,
    output logic [THREAD_IDX_WIDTH-1:0]     ix_thread_idx,
    output logic [SUBCYCLE_WIDTH-1:0]       ix_subcycle,
    output int_exec_pkg::ix_status_t        ix_status,
    output int_exec_pkg::perf_events_t      ix_perf);

    vector_alu #(
        .NUM_LANES(NUM_LANES),
        .NUM_THREADS(NUM_THREADS)
    ) u_vector_alu(
        .clk(clk),
        .operand1(of_operand1),
        .operand2(of_operand2),
        .mask_value(of_mask_value),
        .instruction(of_instruction),
        .thread_idx(of_thread_idx),
        .subcycle(of_subcycle),
        .result(ix_result),
        .mask_value_q(ix_mask_value),
        .instruction_q(ix_instruction),
        .thread_idx_q(ix_thread_idx),
        .subcycle_q(ix_subcycle));

    // Branch conditions and register targets only look at lane 0
    branch_unit #(
        .NUM_THREADS(NUM_THREADS)
    ) u_branch_unit(
        .clk(clk),
        .reset(reset),
        .instruction_valid(of_instruction_valid),
        .instruction(of_instruction),
        .thread_idx(of_thread_idx),
        .operand1_lane0(of_operand1[0]),
        .rollback_en(wb_rollback_en),
        .rollback_thread_idx(wb_rollback_thread_idx),
        .eret_address(cr_eret_address),
        .supervisor_en(cr_supervisor_en),
        .status(ix_status),
        .perf(ix_perf));

endmodule

// File: bench/tb_int_execute_stage.sv
// Testbench for int_execute_stage: clock, reset, file-driven stimulus, checks and report
`timescale 1ns/1ps

module tb_int_execute_stage;

    import int_exec_pkg::*;

    localparam int NUM_LANES = 4;
    localparam int NUM_THREADS = 4;
    localparam int THREAD_BITS = $clog2(NUM_THREADS);
    localparam int RESET_CYCLES = 8;
    localparam int RESET_TIMEOUT = 50;
    localparam int MAX_LINES = 500;
    localparam int NUM_FIELDS = 28;

    logic clk;
    logic reset;
    scalar_t of_operand1[NUM_LANES];
    scalar_t of_operand2[NUM_LANES];
    logic [NUM_LANES-1:0] of_mask_value;
    logic of_instruction_valid;
    instruction_t of_instruction;
    logic [THREAD_BITS-1:0] of_thread_idx;
    logic [1:0] of_subcycle;
    logic wb_rollback_en;
    logic [THREAD_BITS-1:0] wb_rollback_thread_idx;
    scalar_t cr_eret_address[NUM_THREADS];
    logic cr_supervisor_en[NUM_THREADS];
    scalar_t ix_result[NUM_LANES];
    logic [NUM_LANES-1:0] ix_mask_value;
    instruction_t ix_instruction;
    logic [THREAD_BITS-1:0] ix_thread_idx;
    logic [1:0] ix_subcycle;
    ix_status_t ix_status;
    perf_events_t ix_perf;

    int test_errors;
    int pass_count;
    int fail_count;

    int_execute_stage #(
        .NUM_LANES(NUM_LANES),
        .NUM_THREADS(NUM_THREADS)
    ) u_dut(
        .clk(clk),
        .reset(reset),
        .of_operand1(of_operand1),
        .of_operand2(of_operand2),
        .of_mask_value(of_mask_value),
        .of_instruction_valid(of_instruction_valid),
        .of_instruction(of_instruction),
        .of_thread_idx(of_thread_idx),
        .of_subcycle(of_subcycle),
        .wb_rollback_en(wb_rollback_en),
        .wb_rollback_thread_idx(wb_rollback_thread_idx),
        .cr_eret_address(cr_eret_address),
        .cr_supervisor_en(cr_supervisor_en),
        .ix_result(ix_result),
        .ix_mask_value(ix_mask_value),
        .ix_instruction(ix_instruction),
        .ix_thread_idx(ix_thread_idx),
        .ix_subcycle(ix_subcycle),
        .ix_status(ix_status),
        .ix_perf(ix_perf));

    initial clk = 1'b0;
    always #2 clk = ~clk;

    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

    task automatic check_value(input string test_name, input string field,
        input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("mismatch %s %s: expected %h actual %h", test_name, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_test(input string test_name);
        if (test_errors == 0)
        begin
            $display("ok     %s", test_name);
            pass_count++;
        end
        else
        begin
            $display("FAILED %s", test_name);
            fail_count++;
        end
    endtask

    // Columns are described at the top of the stimulus file
    task automatic run_line(input string text, input int line_no);
        string name;
        logic [31:0] op, br, bt, pipe, pc, imm, thr, vld, rb_en, rb_thr;
        logic [31:0] exp_valid, exp_rb_en, exp_rb_pc, exp_fault, exp_perf;
        scalar_t a[NUM_LANES];
        scalar_t b[NUM_LANES];
        scalar_t r[NUM_LANES];
        int fields;
        test_errors = 0;
        fields = $sscanf(text,
            "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            name, op, br, bt, pipe, pc, imm, thr, vld, rb_en, rb_thr,
            a[0], a[1], a[2], a[3], b[0], b[1], b[2], b[3], r[0], r[1], r[2], r[3],
            exp_valid, exp_rb_en, exp_rb_pc, exp_fault, exp_perf);
        if (fields != NUM_FIELDS)
        begin
            name = $sformatf("line_%0d", line_no);
            $display("stimulus line %0d has %0d fields instead of %0d",
                line_no, fields, NUM_FIELDS);
            test_errors++;
        end
        else
        begin
            @(posedge clk);
            #1;
            of_operand1 = a;
            of_operand2 = b;
            of_mask_value = 4'(line_no);
            of_subcycle = 2'(line_no);
            of_thread_idx = thr[THREAD_BITS-1:0];
            of_instruction.alu_op = alu_op_t'(op[5:0]);
            of_instruction.branch = br[0];
            of_instruction.branch_type = branch_type_t'(bt[2:0]);
            of_instruction.pipeline_sel = pipe_sel_t'(pipe[1:0]);
            of_instruction.pc = pc;
            of_instruction.immediate_value = imm;
            of_instruction_valid = vld[0];
            wb_rollback_en = rb_en[0];
            wb_rollback_thread_idx = rb_thr[THREAD_BITS-1:0];
            // Fixed latency of one cycle
            @(posedge clk);
            #1;
            of_instruction_valid = 1'b0;
            wb_rollback_en = 1'b0;
            check_value(name, "instruction_valid", exp_valid, 32'(ix_status.instruction_valid));
            check_value(name, "rollback_en", exp_rb_en, 32'(ix_status.rollback_en));
            check_value(name, "fault", exp_fault, 32'(ix_status.privileged_op_fault));
            check_value(name, "perf", exp_perf, 32'(ix_perf));
            if (exp_rb_en[0])
                check_value(name, "rollback_pc", exp_rb_pc, ix_status.rollback_pc);
            // Result data only matters for a qualified instruction
            if (exp_valid[0])
            begin
                for (int lane = 0; lane < NUM_LANES; lane++)
                    check_value(name, $sformatf("result[%0d]", lane), r[lane], ix_result[lane]);
                check_value(name, "mask", 32'(line_no % 16), 32'(ix_mask_value));
                check_value(name, "subcycle", 32'(line_no % 4), 32'(ix_subcycle));
                check_value(name, "thread_idx", thr, 32'(ix_thread_idx));
                check_value(name, "instruction pc", pc, ix_instruction.pc);
            end
        end
        report_test(name);
    endtask

    initial
    begin
        int fd;
        int line_no;
        int cycles;
        bit setup_ok;
        string text;
        pass_count = 0;
        fail_count = 0;
        setup_ok = 1'b1;
        of_operand1 = '{default: '0};
        of_operand2 = '{default: '0};
        of_mask_value = '0;
        of_instruction_valid = 1'b0;
        of_instruction = '0;
        of_thread_idx = '0;
        of_subcycle = '0;
        wb_rollback_en = 1'b0;
        wb_rollback_thread_idx = '0;
        // Threads 0 and 1 run in supervisor mode, eret address is 0xe000 + 0x10 * thread
        for (int t = 0; t < NUM_THREADS; t++)
        begin
            cr_eret_address[t] = 32'he000 + 32'(t) * 32'h10;
            cr_supervisor_en[t] = t < 2;
        end

        // A qualified taken branch is offered while reset is held
        of_instruction.branch = 1'b1;
        of_instruction.branch_type = BRANCH_ALWAYS;
        of_instruction.pipeline_sel = PIPE_INT_ARITH;
        of_instruction_valid = 1'b1;
        @(posedge clk);
        #1;
        test_errors = 0;
        check_value("reset", "instruction_valid", 32'd0, 32'(ix_status.instruction_valid));
        check_value("reset", "rollback_en", 32'd0, 32'(ix_status.rollback_en));
        check_value("reset", "fault", 32'd0, 32'(ix_status.privileged_op_fault));
        check_value("reset", "perf", 32'd0, 32'(ix_perf));
        report_test("reset");
        of_instruction_valid = 1'b0;
        of_instruction = '0;

        cycles = 0;
        while (reset !== 1'b0 && cycles < RESET_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        fd = $fopen("bench/int_exec_stim.txt", "r");
        if (reset !== 1'b0)
        begin
            $display("reset still asserted after %0d cycles", cycles);
            setup_ok = 1'b0;
        end
        else if (fd == 0)
        begin
            $display("could not open the stimulus file bench/int_exec_stim.txt");
            setup_ok = 1'b0;
        end
        else
        begin
            line_no = 0;
            while (!$feof(fd) && line_no < MAX_LINES)
            begin
                text = "";
                void'($fgets(text, fd));
                line_no++;
                if (text.len() > 1 && text.getc(0) != "#")
                    run_line(text, line_no);
            end
            if (line_no >= MAX_LINES)
            begin
                $display("stimulus file did not end within %0d lines", MAX_LINES);
                setup_ok = 1'b0;
            end
            $fclose(fd);
        end

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (setup_ok && fail_count == 0 && pass_count > 1)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: bench/int_exec_stim.txt
# name op branch btype pipe pc imm thread valid rb_en rb_thread op1[0..3] op2[0..3] (all hex)
# then expected result[0..3] valid rollback_en rollback_pc fault perf(uncond,taken,not_taken)
add 5 0 0 1 0 0 0 1 0 0 1 ffffffff 7fffffff 1234 2 1 1 1111 3 0 80000000 2345 1 0 0 0 0
sub 6 0 0 1 0 0 0 1 0 0 5 0 80000000 10 3 1 1 10 2 ffffffff 7fffffff 0 1 0 0 0 0
and 1 0 0 1 0 0 0 1 0 0 ff00ff00 ffffffff 0 f0f0 ff0 1234 ffffffff 3c3c f00 1234 0 3030 1 0 0 0 0
or 0 0 0 1 0 0 0 1 0 0 ff00ff00 0 1 f0f0 ff0 0 2 f0f ff00fff0 0 3 ffff 1 0 0 0 0
xor 3 0 0 1 0 0 0 1 0 0 ff00 ffffffff 5 aaaa ff0 ffffffff 3 5555 f0f0 0 6 ffff 1 0 0 0 0
move f 0 0 1 0 0 0 1 0 0 1 2 3 4 deadbeef 0 80000000 7 deadbeef 0 80000000 7 1 0 0 0 0
cmpeq 10 0 0 1 0 0 0 1 0 0 3 80000000 1 ffffffff 3 1 80000000 0 1 0 0 0 1 0 0 0 0
cmpne 11 0 0 1 0 0 0 1 0 0 3 80000000 1 ffffffff 3 1 80000000 0 0 1 1 1 1 0 0 0 0
cmpgt_s 12 0 0 1 0 0 0 1 0 0 3 80000000 1 ffffffff 3 1 80000000 0 0 0 1 0 1 0 0 0 0
cmpge_s 13 0 0 1 0 0 0 1 0 0 3 80000000 1 ffffffff 3 1 80000000 0 1 0 1 0 1 0 0 0 0
cmplt_s 14 0 0 1 0 0 0 1 0 0 3 80000000 1 ffffffff 3 1 80000000 0 0 1 0 1 1 0 0 0 0
cmple_s 15 0 0 1 0 0 0 1 0 0 3 80000000 1 ffffffff 3 1 80000000 0 1 1 0 1 1 0 0 0 0
cmpgt_u 16 0 0 1 0 0 0 1 0 0 3 80000000 1 ffffffff 3 1 80000000 0 0 1 0 1 1 0 0 0 0
cmpge_u 17 0 0 1 0 0 0 1 0 0 3 80000000 1 ffffffff 3 1 80000000 0 1 1 0 1 1 0 0 0 0
cmplt_u 18 0 0 1 0 0 0 1 0 0 3 80000000 1 ffffffff 3 1 80000000 0 0 0 1 0 1 0 0 0 0
cmple_u 19 0 0 1 0 0 0 1 0 0 3 80000000 1 ffffffff 3 1 80000000 0 1 0 1 0 1 0 0 0 0
shl b 0 0 1 0 0 0 1 0 0 1 1 80000001 f 4 20 1f 21 10 1 80000000 1e 1 0 0 0 0
shr a 0 0 1 0 0 0 1 0 0 80000000 f0 12345678 ffffffff 1f 4 24 0 1 f 1234567 ffffffff 1 0 0 0 0
ashr 9 0 0 1 0 0 0 1 0 0 80000000 f0 f0000000 7fffffff 1f 4 24 1e ffffffff f ff000000 1 1 0 0 0 0
clz c 0 0 1 0 0 0 1 0 0 0 0 0 0 0 1 80000000 10000 20 1f 0 f 1 0 0 0 0
ctz e 0 0 1 0 0 0 1 0 0 0 0 0 0 0 1 80000000 10000 20 0 1f 10 1 0 0 0 0
sext8 1d 0 0 1 0 0 0 1 0 0 0 0 0 0 7f 80 12345680 ff 7f ffffff80 ffffff80 ffffffff 1 0 0 0 0
sext16 1e 0 0 1 0 0 0 1 0 0 0 0 0 0 7fff 8000 1234abcd ffff 7fff ffff8000 ffffabcd ffffffff 1 0 0 0 0
bz_taken f 1 1 1 1000 40 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1040 0 2
bz_not_taken f 1 1 1 1000 40 0 1 0 0 5 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1
bnz_taken f 1 2 1 1000 40 0 1 0 0 5 0 0 0 0 0 0 0 0 0 0 0 1 1 1040 0 2
bnz_not_taken f 1 2 1 1000 40 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1
b_always f 1 3 1 2000 fffffff0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1ff0 0 4
call_offset f 1 4 1 3000 100 3 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 3100 0 4
call_reg f 1 6 1 3000 100 0 1 0 0 8000 0 0 0 0 0 0 0 0 0 0 0 1 1 8000 0 4
b_reg f 1 0 1 3000 100 1 1 0 0 abcd0 0 0 0 0 0 0 0 0 0 0 0 1 1 abcd0 0 4
eret_super f 1 5 1 500 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 e010 0 4
eret_user f 1 5 1 500 0 2 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 1 0
squash_same f 1 3 1 2000 10 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
pipe_float f 1 3 2 2000 10 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
pipe_mem f 1 3 0 2000 10 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
not_valid f 1 3 1 2000 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
squash_eret f 1 5 1 0 0 2 1 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
rb_other_br 5 1 3 1 4000 4 1 1 1 3 1 2 3 4 10 20 30 40 11 22 33 44 1 1 4004 0 4
rb_other_alu 6 0 0 1 0 0 2 1 1 0 9 9 9 9 1 2 3 4 8 7 6 5 1 0 0 0 0

// File: int_exec.f
verilog/int_exec_pkg.sv
verilog/zero_counter.sv
verilog/lane_alu.sv
verilog/vector_alu.sv
verilog/branch_unit.sv
verilog/int_execute_stage.sv
bench/tb_int_execute_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the int_execute_stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_int_execute_stage \
    -f int_exec.f

output=$(./obj_dir/Vtb_int_execute_stage)
echo "$output"

if grep -q "Test passed" <<< "$output"; then
    exit 0
fi
exit 1
